/* flist.f */
source/gcm_pkg.sv
source/delay_pipe.sv
source/record_fetch.sv
source/cipher_stage.sv
source/out_writer.sv
source/gcm_ipsec_top.sv
tb/gcm_ipsec_assert.sv
tb/tb_gcm_ipsec.sv

/* run.sh */
#!/bin/sh
# Build with Verilator and run from the project root
verilator --binary --timing --assert -Wno-fatal --top-module tb_gcm_ipsec -f flist.f \
    && ./obj_dir/Vtb_gcm_ipsec | tee /dev/stderr | grep -q "SIMULATION PASSED" \
    || exit 1

/* source/cipher_stage.sv */
`timescale 1ns/1ps

module cipher_stage import gcm_pkg::*; #(
    parameter int LAT = CIPHER_LAT
) (
    input  logic   clk,
    input  logic   rstn,
    input  logic   encrypt_ena,
    input  block_t ib_rd_data,
    input  logic   key_ld,
    input  logic   iv_ld,
    input  logic   aad_vld,
    input  size_t  aad_size,
    input  logic   word_vld,
    input  size_t  word_size,
    input  logic   word_last,
    output logic   ct_vld,
    output block_t ct_word,
    output size_t  ct_size,
    output logic   tag_vld,
    output block_t tag_word
);

    localparam int CNT_W = $clog2(LAT + 1);

    block_t           key_hi;
    block_t           key_lo;
    block_t           ctr;
    block_t           tag_acc;
    logic             key_sel;
    block_t           keystream;
    block_t           ct_masked;
    block_t           in_masked;
    block_t           aad_masked;
    logic             tag_pend;
    logic [CNT_W-1:0] tag_cnt;

    // Keep the top s+1 bytes, clear the rest
    function automatic block_t keep_top(block_t w, size_t s);
        block_t m;
        m = ~({BLOCK_W{1'b1}} >> (8 * (int'(s) + 1)));
        return w & m;
    endfunction

    // ========================================================================
    // Keystream and masking
    // ========================================================================
    assign keystream  = key_hi ^ key_lo ^ ctr;
    assign ct_masked  = keep_top(ib_rd_data ^ keystream, word_size);
    assign in_masked  = keep_top(ib_rd_data, word_size);
    assign aad_masked = keep_top(ib_rd_data, aad_size);

    always_ff @(posedge clk) begin
        if (key_ld && !key_sel) begin
            key_hi <= ib_rd_data;
        end
        if (key_ld && key_sel) begin
            key_lo <= ib_rd_data;
        end

        // Counter sits one ahead of the IV for word 0
        if (iv_ld) begin
            ctr <= ib_rd_data + block_t'(1);
        end else if (word_vld) begin
            ctr <= ctr + block_t'(1);
        end

        // Tag seeded with key_hi, GCM folds the ciphertext side
        if (key_ld && !key_sel) begin
            tag_acc <= ib_rd_data;
        end else if (aad_vld) begin
            tag_acc <= tag_acc ^ aad_masked;
        end else if (word_vld) begin
            tag_acc <= tag_acc ^ (encrypt_ena ? ct_masked : in_masked);
        end
    end

    // ========================================================================
    // Tag release after the last word clears the pipe
    // ========================================================================
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            key_sel  <= 1'b0;
            tag_pend <= 1'b0;
            tag_cnt  <= '0;
        end else begin
            if (key_ld) begin
                key_sel <= ~key_sel;
            end
            if (word_last) begin
                tag_pend <= 1'b1;
                tag_cnt  <= CNT_W'(LAT);
            end else if (tag_pend) begin
                if (tag_cnt == '0) begin
                    tag_pend <= 1'b0;
                end else begin
                    tag_cnt <= tag_cnt - 1'b1;
                end
            end
        end
    end

    assign tag_vld  = tag_pend && (tag_cnt == '0);
    assign tag_word = tag_acc;

    delay_pipe #(
        .payload_t (block_t),
        .DEPTH     (LAT)
    ) u_ct_pipe (
        .clk      (clk),
        .rstn     (rstn),
        .in_vld   (word_vld),
        .in_data  (ct_masked),
        .out_vld  (ct_vld),
        .out_data (ct_word)
    );

    delay_pipe #(
        .payload_t (size_t),
        .DEPTH     (LAT)
    ) u_size_pipe (
        .clk      (clk),
        .rstn     (rstn),
        .in_vld   (word_vld),
        .in_data  (word_size),
        .out_vld  (),
        .out_data (ct_size)
    );

endmodule

/* source/delay_pipe.sv */
`timescale 1ns/1ps

module delay_pipe #(
    parameter type payload_t = logic [7:0],
    parameter int  DEPTH     = 1
) (
    input  logic     clk,
    input  logic     rstn,
    input  logic     in_vld,
    input  payload_t in_data,
    output logic     out_vld,
    output payload_t out_data
);

    logic [DEPTH-1:0] vld_q;
    payload_t         data_q [DEPTH];

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            vld_q <= '0;
        end else begin
            vld_q[0] <= in_vld;
            for (int i = 1; i < DEPTH; i++) begin
                vld_q[i] <= vld_q[i-1];
            end
        end
    end

    always_ff @(posedge clk) begin
        data_q[0] <= in_data;
        for (int i = 1; i < DEPTH; i++) begin
            data_q[i] <= data_q[i-1];
        end
    end

    assign out_vld  = vld_q[DEPTH-1];
    assign out_data = data_q[DEPTH-1];

endmodule

/* source/gcm_ipsec_top.sv */
`timescale 1ns/1ps

module gcm_ipsec_top import gcm_pkg::*; #(
    parameter int LAT = CIPHER_LAT
) (
    input  logic   clk,
    input  logic   rstn,
    input  logic   ib_ipsec_valid,
    input  logic   ob_ipsec_valid,
    input  logic   encrypt_ena,
    input  block_t ib_rd_data,
    output logic   ib_pcie_valid,
    output logic   ob_pcie_valid,
    output addr_t  ib_rd_addr,
    output logic   ob_wr_en,
    output addr_t  ob_wr_addr,
    output block_t ob_wr_data
);

    logic   key_ld;
    logic   iv_ld;
    logic   aad_vld;
    size_t  aad_size;
    logic   word_vld;
    size_t  word_size;
    logic   word_last;
    logic   ct_vld;
    block_t ct_word;
    size_t  ct_size;
    logic   tag_vld;
    block_t tag_word;
    logic   rec_done;

    record_fetch u_fetch (
        .clk            (clk),
        .rstn           (rstn),
        .ib_ipsec_valid (ib_ipsec_valid),
        .ob_ipsec_valid (ob_ipsec_valid),
        .ib_rd_data     (ib_rd_data),
        .rec_done       (rec_done),
        .ib_rd_addr     (ib_rd_addr),
        .ib_pcie_valid  (ib_pcie_valid),
        .ob_pcie_valid  (ob_pcie_valid),
        .key_ld         (key_ld),
        .iv_ld          (iv_ld),
        .aad_vld        (aad_vld),
        .aad_size       (aad_size),
        .word_vld       (word_vld),
        .word_size      (word_size),
        .word_last      (word_last),
        .payload_bytes  ()
    );

    cipher_stage #(
        .LAT (LAT)
    ) u_cipher (
        .clk         (clk),
        .rstn        (rstn),
        .encrypt_ena (encrypt_ena),
        .ib_rd_data  (ib_rd_data),
        .key_ld      (key_ld),
        .iv_ld       (iv_ld),
        .aad_vld     (aad_vld),
        .aad_size    (aad_size),
        .word_vld    (word_vld),
        .word_size   (word_size),
        .word_last   (word_last),
        .ct_vld      (ct_vld),
        .ct_word     (ct_word),
        .ct_size     (ct_size),
        .tag_vld     (tag_vld),
        .tag_word    (tag_word)
    );

    out_writer u_writer (
        .clk        (clk),
        .rstn       (rstn),
        .ct_vld     (ct_vld),
        .ct_word    (ct_word),
        .ct_size    (ct_size),
        .tag_vld    (tag_vld),
        .tag_word   (tag_word),
        .ob_wr_en   (ob_wr_en),
        .ob_wr_addr (ob_wr_addr),
        .ob_wr_data (ob_wr_data),
        .rec_done   (rec_done)
    );

endmodule

/* source/gcm_pkg.sv */
package gcm_pkg;

    // ========================================================================
    // Word and count types
    // ========================================================================
    localparam int BLOCK_W = 128;

    typedef logic [BLOCK_W-1:0] block_t;
    typedef logic [7:0]         addr_t;
    typedef logic [10:0]        len_t;
    // Bytes in word minus one
    typedef logic [3:0]         size_t;

    // ========================================================================
    // Buffer map
    // ========================================================================
    localparam addr_t ADDR_INFO   = 8'd1;
    localparam addr_t ADDR_KEY_HI = 8'd2;
    localparam addr_t ADDR_KEY_LO = 8'd3;
    localparam addr_t ADDR_IV     = 8'd4;
    localparam addr_t ADDR_AAD    = 8'd5;
    localparam addr_t ADDR_DATA   = 8'd6;

    localparam addr_t OB_ADDR_INFO = 8'd0;
    localparam addr_t OB_ADDR_DATA = 8'd1;

    // Inbound descriptor
    localparam int AAD_LEN_LSB = 4;
    localparam int AAD_LEN_MSB = 7;
    localparam int PLD_LEN_LSB = 8;
    localparam int PLD_LEN_MSB = 18;

    // Result descriptor, remaining bits zero
    localparam int OB_TAG_LSB = 0;
    localparam int OB_TAG_MSB = 4;
    localparam int OB_CT_LSB  = 5;
    localparam int OB_CT_MSB  = 15;

    localparam int TAG_BYTES  = 16;
    localparam int CIPHER_LAT = 3;

endpackage

/* source/out_writer.sv */
`timescale 1ns/1ps

module out_writer import gcm_pkg::*; (
    input  logic   clk,
    input  logic   rstn,
    input  logic   ct_vld,
    input  block_t ct_word,
    input  size_t  ct_size,
    input  logic   tag_vld,
    input  block_t tag_word,
    output logic   ob_wr_en,
    output addr_t  ob_wr_addr,
    output block_t ob_wr_data,
    output logic   rec_done
);

    addr_t  wr_ptr;
    len_t   ct_bytes;
    logic   info_wr;
    block_t ct_aligned;
    block_t info_word;

    // Valid bytes sit at the top, move them down with zero fill
    assign ct_aligned = ct_word >> (8 * (15 - int'(ct_size)));

    // ========================================================================
    // Result descriptor
    // ========================================================================
    always_comb begin
        info_word = '0;
        info_word[OB_TAG_MSB:OB_TAG_LSB] = TAG_BYTES[OB_TAG_MSB-OB_TAG_LSB:0];
        info_word[OB_CT_MSB:OB_CT_LSB]   = ct_bytes;
    end

    // ========================================================================
    // Write port
    // ========================================================================
    assign ob_wr_en = ct_vld | tag_vld | info_wr;

    always_comb begin
        ob_wr_addr = wr_ptr;
        ob_wr_data = ct_aligned;
        if (info_wr) begin
            ob_wr_addr = OB_ADDR_INFO;
            ob_wr_data = info_word;
        end else if (tag_vld) begin
            ob_wr_data = tag_word;
        end
    end

    // Tag follows the data, descriptor one cycle later
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            wr_ptr   <= OB_ADDR_DATA;
            ct_bytes <= '0;
            info_wr  <= 1'b0;
            rec_done <= 1'b0;
        end else begin
            info_wr  <= tag_vld;
            rec_done <= info_wr;
            if (info_wr) begin
                wr_ptr   <= OB_ADDR_DATA;
                ct_bytes <= '0;
            end else if (ct_vld || tag_vld) begin
                wr_ptr <= addr_t'(wr_ptr + 8'd1);
                if (ct_vld) begin
                    ct_bytes <= ct_bytes + len_t'(ct_size) + 11'd1;
                end
            end
        end
    end

endmodule

/* source/record_fetch.sv */
`timescale 1ns/1ps

module record_fetch import gcm_pkg::*; (
    input  logic   clk,
    input  logic   rstn,
    input  logic   ib_ipsec_valid,
    input  logic   ob_ipsec_valid,
    input  block_t ib_rd_data,
    input  logic   rec_done,
    output addr_t  ib_rd_addr,
    output logic   ib_pcie_valid,
    output logic   ob_pcie_valid,
    output logic   key_ld,
    output logic   iv_ld,
    output logic   aad_vld,
    output size_t  aad_size,
    output logic   word_vld,
    output size_t  word_size,
    output logic   word_last,
    output len_t   payload_bytes
);

    typedef enum logic [3:0] {
        S_IDLE,
        S_INFO,
        S_KEY_HI,
        S_KEY_LO,
        S_IV,
        S_AAD,
        S_DATA,
        S_DRAIN,
        S_WAIT,
        S_DONE
    } state_t;

    state_t     state;
    state_t     state_nxt;
    logic       ipsec_valid_q;
    logic       start;
    logic [3:0] aad_bytes;
    len_t       rem_bytes;

    // Record starts on the rising edge of the host level
    assign start = ib_ipsec_valid & ~ipsec_valid_q;

    // ========================================================================
    // Record FSM
    // ========================================================================
    always_comb begin
        state_nxt = state;
        case (state)
            S_IDLE, S_DONE: begin
                if (start) begin
                    state_nxt = S_INFO;
                end
            end
            S_INFO:   state_nxt = S_KEY_HI;
            S_KEY_HI: state_nxt = S_KEY_LO;
            S_KEY_LO: state_nxt = S_IV;
            S_IV:     state_nxt = S_AAD;
            S_AAD:    state_nxt = S_DATA;
            S_DATA: begin
                if (word_last) begin
                    state_nxt = S_DRAIN;
                end
            end
            S_DRAIN: begin
                if (rec_done) begin
                    state_nxt = S_WAIT;
                end
            end
            S_WAIT: begin
                if (ob_ipsec_valid) begin
                    state_nxt = S_DONE;
                end
            end
            default: state_nxt = S_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state         <= S_IDLE;
            ipsec_valid_q <= 1'b0;
            ib_rd_addr    <= ADDR_INFO;
            rem_bytes     <= '0;
            payload_bytes <= '0;
        end else begin
            state         <= state_nxt;
            ipsec_valid_q <= ib_ipsec_valid;

            // Address leads the state by one cycle, the buffer reads synchronously
            case (state)
                S_IDLE, S_DONE: ib_rd_addr <= start ? ADDR_KEY_HI : ADDR_INFO;
                S_INFO:   ib_rd_addr <= ADDR_KEY_LO;
                S_KEY_HI: ib_rd_addr <= ADDR_IV;
                S_KEY_LO: ib_rd_addr <= ADDR_AAD;
                S_IV:     ib_rd_addr <= ADDR_DATA;
                S_AAD:    ib_rd_addr <= addr_t'(ADDR_DATA + 8'd1);
                S_DATA:   ib_rd_addr <= addr_t'(ib_rd_addr + 8'd1);
                default:  ib_rd_addr <= ADDR_INFO;
            endcase

            if (state == S_INFO) begin
                rem_bytes     <= ib_rd_data[PLD_LEN_MSB:PLD_LEN_LSB];
                payload_bytes <= ib_rd_data[PLD_LEN_MSB:PLD_LEN_LSB];
            end else if (state == S_DATA) begin
                rem_bytes <= word_last ? '0 : rem_bytes - 11'd16;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == S_INFO) begin
            aad_bytes <= ib_rd_data[AAD_LEN_MSB:AAD_LEN_LSB];
        end
    end

    // ========================================================================
    // Strobes to the cipher stage
    // ========================================================================
    assign key_ld   = (state == S_KEY_HI) || (state == S_KEY_LO);
    assign iv_ld    = (state == S_IV);
    assign aad_vld  = (state == S_AAD) && (aad_bytes != 4'd0);
    assign aad_size = aad_bytes - 4'd1;

    // Empty payload still closes the record through word_last
    assign word_vld  = (state == S_DATA) && (rem_bytes != '0);
    assign word_last = (state == S_DATA) && (rem_bytes <= 11'd16);
    assign word_size = (rem_bytes >= 11'd16) ? 4'd15 : rem_bytes[3:0] - 4'd1;

    // Host levels
    assign ib_pcie_valid = (state == S_IDLE) || (state == S_DONE);
    assign ob_pcie_valid = (state == S_WAIT);

endmodule

/* tb/gcm_ipsec_assert.sv */
`timescale 1ns/1ps

module gcm_ipsec_assert (
    input logic clk,
    input logic rstn,
    input logic ib_pcie_valid,
    input logic ob_pcie_valid,
    input logic ob_ipsec_valid,
    input logic ob_wr_en
);

    // No writes once results are announced
    assert property (@(posedge clk) disable iff (!rstn) ob_wr_en |-> !ob_pcie_valid)
        else $error("outbound write while ob_pcie_valid is high");

    // Acknowledge hands the host side back to the inbound level
    assert property (@(posedge clk) disable iff (!rstn)
                     ob_pcie_valid && ob_ipsec_valid |=> ib_pcie_valid && !ob_pcie_valid)
        else $error("host levels did not return to idle after the acknowledge");

    assert property (@(posedge clk) !rstn |-> (ib_pcie_valid && !ob_pcie_valid))
        else $error("host levels wrong during reset");

endmodule

bind gcm_ipsec_top gcm_ipsec_assert u_assert (
    .clk            (clk),
    .rstn           (rstn),
    .ib_pcie_valid  (ib_pcie_valid),
    .ob_pcie_valid  (ob_pcie_valid),
    .ob_ipsec_valid (ob_ipsec_valid),
    .ob_wr_en       (ob_wr_en)
);

/* tb/gcm_vectors.txt */
// 12 words per record: mode (1 = encrypt), descriptor, key_hi, key_lo, IV, AAD,
// payload 0, payload 1, expected data 0, expected data 1, expected tag, result descriptor
// Record 0: encrypt, 32 bytes, AAD 8 bytes
00000000000000000000000000000001
00000000000000000000000000002080
0F000000000000000000000000000000
00F00000000000000000000000000000
00000000000000000000000000000010
112233445566778899AABBCCDDEEFF00
0123456789ABCDEF0123456789ABCDEF
FEDCBA9876543210FEDCBA9876543210
0ED3456789ABCDEF0123456789ABCDFE
F12CBA9876543210FEDCBA9876543202
E1DDCCBBAA998877FFFFFFFFFFFFFFFC
00000000000000000000000000000410
// Record 1: encrypt, 20 bytes, no AAD, IV carry across bit 64
00000000000000000000000000000001
00000000000000000000000000001400
5A5A0000000000000000000000000000
0000A5A5000000000000000000000000
0000000000000000FFFFFFFFFFFFFFFF
00000000000000000000000000000000
00112233445566778899AABBCCDDEEFF
CAFEBABE000000000000000000000000
5A4B8796445566768899AABBCCDDEEFF
0000000000000000000000000090A41F1B
90B5988D445566768899AABBCCDDEEFF
00000000000000000000000000000290
// Record 2: decrypt, 25 bytes, AAD 15 bytes
00000000000000000000000000000000
000000000000000000000000000019F0
000000000000000000000000000000F0
00000000000000000000000000000F00
80000000000000000000000000000000
00112233445566778899AABBCCDDEEFF
FFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFF
01020304050607080900000000000000
7FFFFFFFFFFFFFFFFFFFFFFFFFFFF00E
00000000000000810203040506070809
FEECDEC8BEAC9E807E6655443322110F
00000000000000000000000000000330

/* tb/tb_gcm_ipsec.sv */
`timescale 1ns/1ps

module tb_gcm_ipsec import gcm_pkg::*; ;

    localparam int NUM_RECORDS = 3;
    localparam int REC_WORDS   = 12;
    localparam int NUM_PASSES  = 2;
    localparam int MAX_WORDS   = 2;
    localparam int TIMEOUT_CYCLES = NUM_RECORDS * NUM_PASSES * (MAX_WORDS + 40) + 10;

    logic   clk;
    logic   rstn;
    logic   ib_ipsec_valid;
    logic   ob_ipsec_valid;
    logic   encrypt_ena;
    block_t ib_rd_data;
    logic   ib_pcie_valid;
    logic   ob_pcie_valid;
    addr_t  ib_rd_addr;
    logic   ob_wr_en;
    addr_t  ob_wr_addr;
    block_t ob_wr_data;

    block_t      ib_mem [256];
    block_t      ob_mem [256];
    block_t      vec_mem [NUM_RECORDS * REC_WORDS];
    int          value_errs;
    int          other_errs;
    logic [31:0] rng_state;

    gcm_ipsec_top #(
        .LAT (CIPHER_LAT)
    ) dut0 (
        .clk            (clk),
        .rstn           (rstn),
        .ib_ipsec_valid (ib_ipsec_valid),
        .ob_ipsec_valid (ob_ipsec_valid),
        .encrypt_ena    (encrypt_ena),
        .ib_rd_data     (ib_rd_data),
        .ib_pcie_valid  (ib_pcie_valid),
        .ob_pcie_valid  (ob_pcie_valid),
        .ib_rd_addr     (ib_rd_addr),
        .ob_wr_en       (ob_wr_en),
        .ob_wr_addr     (ob_wr_addr),
        .ob_wr_data     (ob_wr_data)
    );

    always #20 clk = ~clk;

    // ========================================================================
    // Buffer models
    // ========================================================================
    always @(posedge clk) begin
        ib_rd_data <= ib_mem[ib_rd_addr];
        if (ob_wr_en) begin
            ob_mem[ob_wr_addr] <= ob_wr_data;
        end
    end

    function automatic logic [31:0] xorshift32(logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic block_t rand_block();
        block_t w;
        for (int i = 0; i < 4; i++) begin
            rng_state = xorshift32(rng_state);
            w[32*i +: 32] = rng_state;
        end
        return w;
    endfunction

    // Top n bytes set
    function automatic block_t top_mask(int nbytes);
        return ~({BLOCK_W{1'b1}} >> (8 * nbytes));
    endfunction

    // ========================================================================
    // Compare tasks
    // ========================================================================
    task automatic check_block(string name, block_t exp, block_t act);
        if (act !== exp) begin
            value_errs++;
            $display("error %s: expected %032h actual %032h", name, exp, act);
        end
    endtask

    task automatic check_len(string name, len_t exp, len_t act);
        if (act !== exp) begin
            value_errs++;
            $display("error %s: expected %0d actual %0d", name, exp, act);
        end
    endtask

    task automatic check_level(string name, logic exp, logic act);
        if (act !== exp) begin
            value_errs++;
            $display("error %s: expected %b actual %b", name, exp, act);
        end
    endtask

    // Padding beyond the AAD and payload lengths is random
    task automatic load_record(int r);
        int     base;
        int     len;
        int     aad_n;
        int     nw;
        int     tail;
        block_t m;
        base  = r * REC_WORDS;
        len   = int'(vec_mem[base+1][PLD_LEN_MSB:PLD_LEN_LSB]);
        aad_n = int'(vec_mem[base+1][AAD_LEN_MSB:AAD_LEN_LSB]);
        nw    = (len + 15) / 16;
        for (int a = 0; a < 256; a++) begin
            ib_mem[a] = rand_block();
        end
        ib_mem[ADDR_INFO]   = vec_mem[base+1];
        ib_mem[ADDR_KEY_HI] = vec_mem[base+2];
        ib_mem[ADDR_KEY_LO] = vec_mem[base+3];
        ib_mem[ADDR_IV]     = vec_mem[base+4];
        m = top_mask(aad_n);
        ib_mem[ADDR_AAD] = (vec_mem[base+5] & m) | (ib_mem[ADDR_AAD] & ~m);
        for (int i = 0; i < nw; i++) begin
            tail = (i == nw - 1 && len % 16 != 0) ? len % 16 : 16;
            m = top_mask(tail);
            ib_mem[ADDR_DATA+i] = (vec_mem[base+6+i] & m) | (ib_mem[ADDR_DATA+i] & ~m);
        end
    endtask

    task automatic run_record(int r, int pass);
        int    base;
        int    nw;
        len_t  len;
        string tn;
        base = r * REC_WORDS;
        len  = vec_mem[base+1][PLD_LEN_MSB:PLD_LEN_LSB];
        nw   = (int'(len) + 15) / 16;
        tn   = $sformatf("rec%0d pass%0d", r, pass);
        load_record(r);
        @(posedge clk);
        encrypt_ena    <= vec_mem[base][0];
        ib_ipsec_valid <= 1'b1;
        @(negedge clk);
        while (!ob_pcie_valid) begin
            @(negedge clk);
        end
        check_level({tn, " ib_pcie_valid in wait"}, 1'b0, ib_pcie_valid);
        for (int i = 0; i < nw; i++) begin
            check_block($sformatf("%s data%0d", tn, i), vec_mem[base+8+i],
                        ob_mem[OB_ADDR_DATA+i]);
        end
        check_block({tn, " tag"}, vec_mem[base+10], ob_mem[OB_ADDR_DATA+nw]);
        check_block({tn, " descriptor"}, vec_mem[base+11], ob_mem[OB_ADDR_INFO]);
        check_len({tn, " ct bytes"}, len, ob_mem[OB_ADDR_INFO][OB_CT_MSB:OB_CT_LSB]);

        // Host acknowledges and drops the start level
        @(posedge clk);
        ob_ipsec_valid <= 1'b1;
        ib_ipsec_valid <= 1'b0;
        @(negedge clk);
        while (!ib_pcie_valid) begin
            @(negedge clk);
        end
        check_level({tn, " ob_pcie_valid after ack"}, 1'b0, ob_pcie_valid);
        @(posedge clk);
        ob_ipsec_valid <= 1'b0;
    endtask

    // ========================================================================
    // Main sequence
    // ========================================================================
    initial begin
        clk            = 1'b0;
        rstn           = 1'b0;
        ib_ipsec_valid = 1'b0;
        ob_ipsec_valid = 1'b0;
        encrypt_ena    = 1'b0;
        ib_rd_data     = '0;
        value_errs     = 0;
        other_errs     = 0;
        rng_state      = 32'h3ce69593;
        $readmemh("tb/gcm_vectors.txt", vec_mem);
        if ($isunknown(vec_mem[NUM_RECORDS*REC_WORDS-1]) ||
            vec_mem[NUM_RECORDS*REC_WORDS-1] == '0) begin
            other_errs++;
            $display("vector file tb/gcm_vectors.txt is missing or too short");
        end
        repeat (3) @(posedge clk);
        rstn <= 1'b1;
        @(negedge clk);
        check_level("reset ib_pcie_valid", 1'b1, ib_pcie_valid);
        check_level("reset ob_pcie_valid", 1'b0, ob_pcie_valid);
        check_level("reset ob_wr_en", 1'b0, ob_wr_en);
        if (other_errs == 0) begin
            for (int p = 0; p < NUM_PASSES; p++) begin
                for (int r = 0; r < NUM_RECORDS; r++) begin
                    run_record(r, p);
                end
            end
        end
        $display("errors: %0d value, %0d other", value_errs, other_errs);
        if (value_errs == 0 && other_errs == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

    // Watchdog
    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("timeout: DUT did not finish the records in %0d cycles", TIMEOUT_CYCLES);
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule
